/* common/io_consts.svh */
`ifndef IO_CONSTS_SVH
`define IO_CONSTS_SVH

// Requesting cores on the fabric
`define NUM_CORES 4
// Hardware threads inside each core
`define THREADS_PER_CORE 4

// Bus address and data widths
`define IO_ADDR_WIDTH 8
`define IO_DATA_WIDTH 32

// Tag widths carried with each request
`define CORE_ID_WIDTH 2
`define THREAD_IDX_WIDTH 2

// Scratch registers in the device
`define NUM_SCRATCH_REGS 4
`endif

/* common/io_req_pkg.sv */
`include "io_consts.svh"

package io_req_pkg;

    // Core number, also the arbiter grant index
    typedef logic [`CORE_ID_WIDTH-1:0] core_id_t;

    // Thread number inside a core
    typedef logic [`THREAD_IDX_WIDTH-1:0] thread_idx_t;

    // Request from a core, held until its ready pulse
    typedef struct packed {
        logic                      valid;
        logic                      is_store;
        thread_idx_t               thread_idx;
        logic [`IO_ADDR_WIDTH-1:0] address;
        logic [`IO_DATA_WIDTH-1:0] value;
    } ioreq_packet_t;

    // Tagged response, valid for a single cycle
    typedef struct packed {
        logic                      valid;
        core_id_t                  core;
        thread_idx_t               thread_idx;
        logic [`IO_DATA_WIDTH-1:0] read_value;
    } iorsp_packet_t;

endpackage

/* common/io_dev_pkg.sv */
`include "io_consts.svh"

package io_dev_pkg;

    // Strobes are high only in the grant cycle
    typedef struct packed {
        logic                      read_en;
        logic                      write_en;
        logic [`IO_ADDR_WIDTH-1:0] address;
        logic [`IO_DATA_WIDTH-1:0] write_data;
    } io_bus_req_t;

    // Device register map
    typedef enum logic [`IO_ADDR_WIDTH-1:0] {
        REG_SCRATCH0     = 8'h00,
        REG_SCRATCH1     = 8'h01,
        REG_SCRATCH2     = 8'h02,
        REG_SCRATCH3     = 8'h03,
        REG_TIMER_LOAD   = 8'h04,
        REG_TIMER_CTRL   = 8'h05,
        REG_TIMER_COUNT  = 8'h06,
        REG_TIMER_STATUS = 8'h07
    } io_reg_t;

    typedef enum logic [1:0] {TIMER_IDLE, TIMER_RUNNING, TIMER_EXPIRED} timer_state_t;

    // Bit 0 is start, bit 1 is auto_reload
    typedef struct packed {
        logic auto_reload;
        logic start;
    } timer_ctrl_t;

endpackage

/* io_interconnect/rr_arbiter.sv */
`include "io_consts.svh"

module rr_arbiter
    import io_req_pkg::*;
#(
    parameter int NUM_REQUESTERS = `NUM_CORES
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [NUM_REQUESTERS-1:0] request,
    output logic [NUM_REQUESTERS-1:0] grant_oh,
    output core_id_t                  grant_idx
);

    // Index of the most recent winner
    core_id_t last_idx;

    always_comb
    begin
        int   cand;
        logic found;
        found = 1'b0;
        grant_oh = '0;
        grant_idx = '0;
        // Search starts one past the last winner and wraps
        for (int i = 1; i <= NUM_REQUESTERS; i++)
        begin
            cand = (int'(last_idx) + i) % NUM_REQUESTERS;
            if (!found && request[cand])
            begin
                found = 1'b1;
                grant_oh[cand] = 1'b1;
            end
        end
        // One-hot to index, OR of the set position
        for (int j = 0; j < NUM_REQUESTERS; j++)
            if (grant_oh[j])
                grant_idx |= core_id_t'(j);
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            last_idx <= core_id_t'(NUM_REQUESTERS - 1);
        else if (|grant_oh)
            last_idx <= grant_idx;
    end

endmodule

/* io_interconnect/io_interconnect.sv */
`include "io_consts.svh"

module io_interconnect
    import io_req_pkg::*;
    import io_dev_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  ioreq_packet_t             io_request [`NUM_CORES],
    output logic                      ii_ready [`NUM_CORES],
    output iorsp_packet_t             ii_response,
    output io_bus_req_t               bus_req,
    input  logic [`IO_DATA_WIDTH-1:0] read_data
);

    logic [`NUM_CORES-1:0] arb_request;
    logic [`NUM_CORES-1:0] grant_oh;
    core_id_t              grant_idx;
    ioreq_packet_t         grant_request;
    // Tags of the request whose read data arrives this cycle
    logic                  request_sent;
    core_id_t              request_core;
    thread_idx_t           request_thread_idx;

    // Valid bits feed the arbiter, grants come back as ready
    for (genvar i = 0; i < `NUM_CORES; i++)
    begin : g_handshake
        assign arb_request[i] = io_request[i].valid;
        assign ii_ready[i] = grant_oh[i];
    end

    if (`NUM_CORES > 1)
    begin : g_arb
        rr_arbiter #(.NUM_REQUESTERS(`NUM_CORES)) u_arbiter (
            .clk      (clk),
            .reset    (reset),
            .request  (arb_request),
            .grant_oh (grant_oh),
            .grant_idx(grant_idx)
        );
    end
    else
    begin : g_single
        // Lone core always wins
        assign grant_oh = arb_request;
        assign grant_idx = '0;
    end

    assign grant_request = io_request[grant_idx];

    // Same-cycle strobe onto the bus
    assign bus_req.write_en = |grant_oh && grant_request.is_store;
    assign bus_req.read_en = |grant_oh && !grant_request.is_store;
    assign bus_req.address = grant_request.address;
    assign bus_req.write_data = grant_request.value;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            request_sent <= 1'b0;
            request_core <= '0;
            request_thread_idx <= '0;
            ii_response <= '0;
        end
        else
        begin
            // Stage 1 holds the tags while the device answers
            request_sent <= |grant_oh;
            if (|grant_oh)
            begin
                request_core <= grant_idx;
                request_thread_idx <= grant_request.thread_idx;
            end

            // Stage 2 pairs the tags with the registered read data
            ii_response.valid <= request_sent;
            if (request_sent)
            begin
                ii_response.core <= request_core;
                ii_response.thread_idx <= request_thread_idx;
                ii_response.read_value <= read_data;
            end
        end
    end

endmodule

/* src/timer_counter.sv */
`include "io_consts.svh"

module timer_counter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      load,
    input  logic [`IO_DATA_WIDTH-1:0] load_value,
    input  logic                      decrement,
    output logic [`IO_DATA_WIDTH-1:0] count,
    output logic                      zero
);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            count <= '0;
        // Load wins over decrement
        else if (load)
            count <= load_value;
        // Saturates at zero
        else if (decrement && count != '0)
            count <= count - 1'b1;
    end

    assign zero = count == '0;

endmodule

/* src/timer_fsm.sv */
module timer_fsm
    import io_dev_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         ctrl_write,
    input  timer_ctrl_t  timer_ctrl,
    input  logic         counter_zero,
    output logic         load,
    output logic         decrement,
    output timer_state_t timer_state,
    output logic         timer_expired
);

    timer_state_t next_state;
    // Auto-reload mode captured at the last start
    logic         auto_reload_q;

    always_comb
    begin
        next_state = timer_state;
        load = 1'b0;
        decrement = 1'b0;
        if (ctrl_write)
        begin
            // A control write overrides the current state
            load = timer_ctrl.start;
            next_state = timer_ctrl.start ? TIMER_RUNNING : TIMER_IDLE;
        end
        else
        begin
            case (timer_state)
                TIMER_RUNNING:
                    if (counter_zero)
                        next_state = TIMER_EXPIRED;
                    else
                        decrement = 1'b1;
                TIMER_EXPIRED:
                begin
                    load = auto_reload_q;
                    next_state = auto_reload_q ? TIMER_RUNNING : TIMER_IDLE;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            timer_state <= TIMER_IDLE;
            auto_reload_q <= 1'b0;
        end
        else
        begin
            timer_state <= next_state;
            if (ctrl_write)
                auto_reload_q <= timer_ctrl.auto_reload;
        end
    end

    // Pulse lasts exactly the one EXPIRED cycle
    assign timer_expired = timer_state == TIMER_EXPIRED;

endmodule

/* src/io_device.sv */
`include "io_consts.svh"

module io_device
    import io_dev_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  io_bus_req_t               bus_req,
    output logic [`IO_DATA_WIDTH-1:0] read_data,
    output logic [`IO_DATA_WIDTH-1:0] timer_load,
    output logic                      ctrl_write,
    output timer_ctrl_t               timer_ctrl,
    input  logic [`IO_DATA_WIDTH-1:0] timer_count,
    input  timer_state_t              timer_state
);

    localparam int SCRATCH_IDX_W = $clog2(`NUM_SCRATCH_REGS);

    io_reg_t                   reg_addr;
    logic [`IO_DATA_WIDTH-1:0] scratch [`NUM_SCRATCH_REGS];
    logic [SCRATCH_IDX_W-1:0]  scratch_idx;
    timer_ctrl_t               ctrl_q;
    logic [7:0]                expire_count;
    logic [`IO_DATA_WIDTH-1:0] read_mux;

    assign reg_addr = io_reg_t'(bus_req.address);
    assign scratch_idx = bus_req.address[SCRATCH_IDX_W-1:0];

    // Control goes straight to the FSM so it acts in the write cycle
    assign ctrl_write = bus_req.write_en && reg_addr == REG_TIMER_CTRL;
    assign timer_ctrl = timer_ctrl_t'(bus_req.write_data[1:0]);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < `NUM_SCRATCH_REGS; i++)
                scratch[i] <= '0;
            timer_load <= '0;
            ctrl_q <= '0;
        end
        else if (bus_req.write_en)
        begin
            case (reg_addr)
                REG_SCRATCH0, REG_SCRATCH1, REG_SCRATCH2, REG_SCRATCH3:
                    scratch[scratch_idx] <= bus_req.write_data;
                REG_TIMER_LOAD: timer_load <= bus_req.write_data;
                REG_TIMER_CTRL: ctrl_q <= timer_ctrl;
                // Count and status are read only
                default: ;
            endcase
        end
    end

    // Status is {expire_count, state} in the low 16 bits
    always_comb
    begin
        case (reg_addr)
            REG_SCRATCH0, REG_SCRATCH1, REG_SCRATCH2, REG_SCRATCH3:
                read_mux = scratch[scratch_idx];
            REG_TIMER_LOAD:   read_mux = timer_load;
            REG_TIMER_CTRL:   read_mux = `IO_DATA_WIDTH'(ctrl_q);
            REG_TIMER_COUNT:  read_mux = timer_count;
            REG_TIMER_STATUS: read_mux = `IO_DATA_WIDTH'({expire_count, 6'b0, timer_state});
            default:          read_mux = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            read_data <= '0;
            expire_count <= '0;
        end
        else
        begin
            // Writes leave the last read value in place
            if (bus_req.read_en)
                read_data <= read_mux;
            // One count per expiry cycle, wraps at 256
            if (timer_state == TIMER_EXPIRED)
                expire_count <= expire_count + 8'd1;
        end
    end

endmodule

/* src/io_subsystem.sv */
`include "io_consts.svh"

module io_subsystem
    import io_req_pkg::*;
    import io_dev_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  ioreq_packet_t io_request [`NUM_CORES],
    output logic          ii_ready [`NUM_CORES],
    output iorsp_packet_t ii_response,
    output logic          timer_expired
);

    io_bus_req_t               bus_req;
    logic [`IO_DATA_WIDTH-1:0] read_data;
    // Timer control path from the device
    logic [`IO_DATA_WIDTH-1:0] timer_load;
    logic                      ctrl_write;
    timer_ctrl_t               timer_ctrl;
    // Counter and FSM handshake
    logic [`IO_DATA_WIDTH-1:0] timer_count;
    logic                      counter_zero;
    logic                      counter_load;
    logic                      counter_decrement;
    timer_state_t              timer_state;

    io_interconnect u_interconnect (
        .clk(clk), .reset(reset), .io_request(io_request), .ii_ready(ii_ready),
        .ii_response(ii_response), .bus_req(bus_req), .read_data(read_data)
    );

    io_device u_device (
        .clk(clk), .reset(reset), .bus_req(bus_req), .read_data(read_data),
        .timer_load(timer_load), .ctrl_write(ctrl_write), .timer_ctrl(timer_ctrl),
        .timer_count(timer_count), .timer_state(timer_state)
    );

    timer_fsm u_timer_fsm (
        .clk(clk), .reset(reset), .ctrl_write(ctrl_write), .timer_ctrl(timer_ctrl),
        .counter_zero(counter_zero), .load(counter_load), .decrement(counter_decrement),
        .timer_state(timer_state), .timer_expired(timer_expired)
    );

    timer_counter u_timer_counter (
        .clk(clk), .reset(reset), .load(counter_load), .load_value(timer_load),
        .decrement(counter_decrement), .count(timer_count), .zero(counter_zero)
    );

endmodule

/* dv/io_subsystem_props.sv */
`include "io_consts.svh"

module io_subsystem_props
    import io_req_pkg::*;
(
    input logic          clk,
    input logic          reset,
    input ioreq_packet_t io_request [`NUM_CORES],
    input logic          ii_ready [`NUM_CORES],
    input iorsp_packet_t ii_response,
    input logic          timer_expired
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`NUM_CORES-1:0] ready_vec;
    logic [`NUM_CORES-1:0] valid_vec;

    for (genvar i = 0; i < `NUM_CORES; i++)
    begin : g_flatten
        assign ready_vec[i] = ii_ready[i];
        assign valid_vec[i] = io_request[i].valid;
    end

    // One winner per cycle at most
    a_single_grant: assert property (@(posedge clk) disable iff (reset) $onehot0(ready_vec))
        else $error("more than one ii_ready high in a cycle");

    // No back-pressure, some core always wins
    a_grant_on_request: assert property (@(posedge clk) disable iff (reset)
        |valid_vec |-> |ready_vec)
        else $error("valid request without any ii_ready");

    // Two-stage pipeline from grant to response
    a_response_delay: assert property (@(posedge clk) disable iff (reset)
        ii_response.valid == $past(|ready_vec, 2))
        else $error("response valid does not follow a grant by two cycles");

    a_expiry_pulse: assert property (@(posedge clk) disable iff (reset)
        timer_expired |=> !timer_expired)
        else $error("timer_expired high in two consecutive cycles");

endmodule

bind io_subsystem io_subsystem_props u_props (
    .clk(clk), .reset(reset), .io_request(io_request), .ii_ready(ii_ready),
    .ii_response(ii_response), .timer_expired(timer_expired)
);

/* dv/io_subsystem_tb.sv */
`include "io_consts.svh"

module io_subsystem_tb
    import io_req_pkg::*;
    import io_dev_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 20;
    localparam int RANDOM_TXNS = 12;
    localparam int ONESHOT_LOAD = 5;
    localparam int RELOAD_LOAD = 3;
    localparam int RELOAD_PULSES = 3;
    // Each request waits at most a full rotation, timer phases add their periods
    localparam int TIMEOUT_CYCLES = (`NUM_CORES * (RANDOM_TXNS + 4) + 16) * `NUM_CORES
        + (ONESHOT_LOAD + 2) * 2 + (RELOAD_LOAD + 2) * (RELOAD_PULSES + 2) + 200;

    logic          clk;
    logic          reset;
    ioreq_packet_t io_request [`NUM_CORES];
    logic          ii_ready [`NUM_CORES];
    iorsp_packet_t ii_response;
    logic          timer_expired;

    // Per-core transactions not yet presented
    ioreq_packet_t pending [`NUM_CORES][$];
    logic          ready_seen [`NUM_CORES];
    logic          gaps_on;
    logic [15:0]   lfsr_state;
    int            pulses_seen;

    // Reference model of the device, timer and arbiter
    logic [`IO_DATA_WIDTH-1:0] ref_scratch [`NUM_SCRATCH_REGS];
    logic [`IO_DATA_WIDTH-1:0] ref_load;
    logic [`IO_DATA_WIDTH-1:0] ref_count;
    logic [`IO_DATA_WIDTH-1:0] ref_last_read;
    logic [1:0]                ref_ctrl;
    logic                      ref_auto;
    logic [7:0]                ref_expire_cnt;
    timer_state_t              ref_state;
    core_id_t                  ref_last_core;
    // Expected responses, index 1 is due this cycle
    iorsp_packet_t             exp_rsp [2];

    io_subsystem UUT (
        .clk(clk), .reset(reset), .io_request(io_request), .ii_ready(ii_ready),
        .ii_response(ii_response), .timer_expired(timer_expired)
    );

    // Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    // Response the register map gives for a request in the current model state
    function automatic iorsp_packet_t expected_response(input core_id_t core,
                                                        input ioreq_packet_t req);
        iorsp_packet_t rsp;
        rsp.valid = 1'b1;
        rsp.core = core;
        rsp.thread_idx = req.thread_idx;
        rsp.read_value = '0;
        // Stores return whatever the last read left behind
        if (req.is_store)
            rsp.read_value = ref_last_read;
        else if (req.address < `NUM_SCRATCH_REGS)
            rsp.read_value = ref_scratch[req.address[1:0]];
        else if (req.address == REG_TIMER_LOAD)
            rsp.read_value = ref_load;
        else if (req.address == REG_TIMER_CTRL)
            rsp.read_value = {30'b0, ref_ctrl};
        else if (req.address == REG_TIMER_COUNT)
            rsp.read_value = ref_count;
        else if (req.address == REG_TIMER_STATUS)
            rsp.read_value = {16'b0, ref_expire_cnt, 6'b0, ref_state};
        return rsp;
    endfunction

    // One clock of timer and register state
    task automatic advance_model(input logic granted, input ioreq_packet_t req);
        logic ctrl_wr;
        ctrl_wr = granted && req.is_store && req.address == REG_TIMER_CTRL;
        if (ref_state == TIMER_EXPIRED)
            ref_expire_cnt = ref_expire_cnt + 8'd1;
        if (ctrl_wr)
        begin
            ref_auto = req.value[1];
            ref_state = req.value[0] ? TIMER_RUNNING : TIMER_IDLE;
            if (req.value[0])
                ref_count = ref_load;
        end
        else if (ref_state == TIMER_RUNNING)
        begin
            if (ref_count == '0)
                ref_state = TIMER_EXPIRED;
            else
                ref_count = ref_count - 1;
        end
        else if (ref_state == TIMER_EXPIRED)
        begin
            ref_state = ref_auto ? TIMER_RUNNING : TIMER_IDLE;
            if (ref_auto)
                ref_count = ref_load;
        end
        // Register writes land after the timer used the old load value
        if (granted && req.is_store)
        begin
            if (req.address < `NUM_SCRATCH_REGS)
                ref_scratch[req.address[1:0]] = req.value;
            else if (req.address == REG_TIMER_LOAD)
                ref_load = req.value;
            else if (req.address == REG_TIMER_CTRL)
                ref_ctrl = req.value[1:0];
        end
    endtask

    task automatic report_mismatch(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic queue_request(input int core, input logic is_store, input thread_idx_t thread,
                                 input logic [`IO_ADDR_WIDTH-1:0] addr,
                                 input logic [`IO_DATA_WIDTH-1:0] value);
        ioreq_packet_t pkt;
        pkt.valid = 1'b1;
        pkt.is_store = is_store;
        pkt.thread_idx = thread;
        pkt.address = addr;
        pkt.value = value;
        pending[core].push_back(pkt);
    endtask

    // Stores hit scratch only, loads cover the whole map
    task automatic queue_random(input int core);
        logic                      is_store;
        thread_idx_t               thread;
        logic [`IO_ADDR_WIDTH-1:0] addr;
        logic [`IO_DATA_WIDTH-1:0] value;
        is_store = 1'(random_bits(1));
        thread = thread_idx_t'(random_bits(2));
        addr = is_store ? `IO_ADDR_WIDTH'(random_bits(2)) : `IO_ADDR_WIDTH'(random_bits(3));
        value = random_bits(32);
        queue_request(core, is_store, thread, addr, value);
    endtask

    // Returns on a falling edge once all queues are empty and responses are in
    task automatic wait_drained();
        logic busy;
        busy = 1'b1;
        while (busy)
        begin
            @(negedge clk);
            busy = 1'b0;
            for (int c = 0; c < `NUM_CORES; c++)
                if (pending[c].size() != 0 || io_request[c].valid)
                    busy = 1'b1;
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic wait_for_pulses(input int count);
        int start;
        @(posedge clk);
        start = pulses_seen;
        while (pulses_seen < start + count)
            @(posedge clk);
        @(negedge clk);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Present the next queued request once the held one has seen ready
    always @(posedge clk)
    begin
        if (!reset)
            for (int c = 0; c < `NUM_CORES; c++)
                if (!io_request[c].valid || ready_seen[c])
                begin
                    if (pending[c].size() > 0 && (!gaps_on || random_bits(1) == 1))
                        io_request[c] <= pending[c].pop_front();
                    else
                        io_request[c] <= '0;
                end
    end

    // Mid-cycle check of grant, response and expiry against the model
    always @(negedge clk)
    begin : compare_outputs
        logic     granted;
        core_id_t win;
        int       cand;
        granted = 1'b0;
        win = '0;
        if (!reset)
        begin
            // First valid core after the last winner, with wraparound
            for (int i = 1; i <= `NUM_CORES; i++)
            begin
                cand = (int'(ref_last_core) + i) % `NUM_CORES;
                if (!granted && io_request[cand].valid)
                begin
                    granted = 1'b1;
                    win = core_id_t'(cand);
                end
            end
            for (int c = 0; c < `NUM_CORES; c++)
            begin
                ready_seen[c] = ii_ready[c];
                assert (ii_ready[c] == (granted && win == core_id_t'(c)))
                    else report_mismatch($sformatf("core %0d ready %0b, expected winner %0d",
                                                   c, ii_ready[c], win));
            end
            assert (ii_response.valid == exp_rsp[1].valid)
                else report_mismatch($sformatf("response valid %0b, expected %0b",
                                               ii_response.valid, exp_rsp[1].valid));
            if (exp_rsp[1].valid)
                assert (ii_response == exp_rsp[1])
                    else report_mismatch($sformatf("response %h, expected %h",
                                                   ii_response, exp_rsp[1]));
            assert (timer_expired == (ref_state == TIMER_EXPIRED))
                else report_mismatch($sformatf("timer_expired %0b in state %s",
                                               timer_expired, ref_state.name()));
            if (timer_expired)
                pulses_seen++;
            exp_rsp[1] = exp_rsp[0];
            exp_rsp[0] = granted ? expected_response(win, io_request[win]) : '0;
            if (granted)
            begin
                ref_last_core = win;
                if (!io_request[win].is_store)
                    ref_last_read = exp_rsp[0].read_value;
            end
            advance_model(granted, io_request[win]);
        end
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $fatal(1);
    end

    initial
    begin
        int pulses_at_stop;
        reset <= 1'b1;
        gaps_on = 1'b1;
        lfsr_state = 16'd48;
        pulses_seen = 0;
        for (int c = 0; c < `NUM_CORES; c++)
        begin
            io_request[c] <= '0;
            ready_seen[c] = 1'b0;
        end
        for (int r = 0; r < `NUM_SCRATCH_REGS; r++)
            ref_scratch[r] = '0;
        ref_load = '0;
        ref_count = '0;
        ref_last_read = '0;
        ref_ctrl = '0;
        ref_auto = 1'b0;
        ref_expire_cnt = '0;
        ref_state = TIMER_IDLE;
        ref_last_core = core_id_t'(`NUM_CORES - 1);
        exp_rsp[0] = '0;
        exp_rsp[1] = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        // Random scratch traffic with random request gaps
        for (int n = 0; n < RANDOM_TXNS; n++)
            for (int c = 0; c < `NUM_CORES; c++)
                queue_random(c);
        wait_drained();

        // All cores requesting back to back, grants must rotate
        gaps_on = 1'b0;
        for (int n = 0; n < 4; n++)
            for (int c = 0; c < `NUM_CORES; c++)
                queue_request(c, 1'b0, thread_idx_t'(random_bits(2)), 8'(n), '0);
        wait_drained();

        // One-shot timer, then status back in IDLE
        queue_request(0, 1'b1, 2'd0, REG_TIMER_LOAD, ONESHOT_LOAD);
        queue_request(0, 1'b1, 2'd0, REG_TIMER_CTRL, 32'h1);
        wait_drained();
        wait_for_pulses(1);
        queue_request(1, 1'b0, 2'd1, REG_TIMER_STATUS, '0);
        wait_drained();

        // Auto-reload for a few periods, then stop
        queue_request(2, 1'b1, 2'd3, REG_TIMER_LOAD, RELOAD_LOAD);
        queue_request(2, 1'b1, 2'd3, REG_TIMER_CTRL, 32'h3);
        wait_drained();
        wait_for_pulses(RELOAD_PULSES);
        queue_request(3, 1'b0, 2'd2, REG_TIMER_STATUS, '0);
        queue_request(3, 1'b1, 2'd2, REG_TIMER_CTRL, 32'h0);
        wait_drained();
        @(posedge clk);
        pulses_at_stop = pulses_seen;
        repeat (2 * (RELOAD_LOAD + 2)) @(posedge clk);
        assert (pulses_seen == pulses_at_stop)
            else report_mismatch("timer_expired pulsed after the stop write");
        @(negedge clk);
        queue_request(0, 1'b0, 2'd0, REG_TIMER_STATUS, '0);
        wait_drained();
        // Last response is the status read, its count covers every pulse of the run
        assert (ii_response.read_value[15:8] == 8'(pulses_seen))
            else report_mismatch($sformatf("status expiry count %0d, pulses seen %0d",
                                           ii_response.read_value[15:8], pulses_seen));

        $display("Testbench passed");
        $finish;
    end

endmodule

/* list.f */
+incdir+common
common/io_req_pkg.sv
common/io_dev_pkg.sv
io_interconnect/rr_arbiter.sv
io_interconnect/io_interconnect.sv
src/timer_counter.sv
src/timer_fsm.sv
src/io_device.sv
src/io_subsystem.sv
dv/io_subsystem_props.sv
dv/io_subsystem_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench, the exit status carries pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f list.f --top-module io_subsystem_tb -o io_subsystem_sim \
    && ./obj_dir/io_subsystem_sim \
    || exit 1
